// File: source/videoOut_consts.svh
`ifndef VIDEOOUT_CONSTS_SVH
`define VIDEOOUT_CONSTS_SVH

// ==============================
// Widths
// ==============================

// Palette index as seen by the raster side
`define PAL_INDEX_W   12
// One palette entry, dark bit plus 5:5:5 colour
`define PAL_ENTRY_W   16
// Output colour channel
`define CHAN_W        8
// Host byte address and data bus
`define HOST_ADDR_W   24
`define HOST_DATA_W   16

// ==============================
// Timing and decode
// ==============================

// Master clocks per pixel, 48 MHz down to 6 MHz
`define PIX_DIV       8

// Palette zone, address bits 23:22
`define ZONE_PAL      2'b01
// Latch zone, address bits 23:16
`define ZONE_LATCH    8'h3A

// Latch bit numbers, selected by address bits 3:1
`define LATCH_SHADOW  3'd0
`define LATCH_PALBANK 3'd7

`endif

// File: source/hostBusPkg.sv
`default_nettype none

// ==============================
// Host write bus types
// ==============================

package hostBusPkg;

	`include "videoOut_consts.svh"

	// Byte address as driven by the host CPU
	// Bit 0 is never used, the bus moves whole words
	typedef logic [`HOST_ADDR_W-1:0] hostAddrT;

	// Word written by the host
	typedef logic [`HOST_DATA_W-1:0] hostDataT;

	// Latch bit select, taken from address bits 3:1
	typedef logic [2:0] latchSelT;

	// Palette zone code, address bits 23:22
	typedef logic [1:0] palZoneT;

	// Latch zone code, address bits 23:16
	typedef logic [7:0] latchZoneT;

endpackage

`default_nettype wire

// File: source/videoPkg.sv
`default_nettype none

// ==============================
// Palette and colour types
// ==============================

package videoPkg;

	`include "videoOut_consts.svh"

	// Index into one palette bank
	typedef logic [`PAL_INDEX_W-1:0] palIndexT;

	// RAM address, bank bit on top of the index
	typedef logic [`PAL_INDEX_W:0] palAddrT;

	// Palette entry layout
	//   15     dark, one step off every channel
	//   14     red low bit
	//   13     green low bit
	//   12     blue low bit
	//   11:8   red high nibble
	//   7:4    green high nibble
	//   3:0    blue high nibble
	typedef logic [`PAL_ENTRY_W-1:0] palEntryT;

	// Four bit high part of one channel
	typedef logic [3:0] nibbleT;

	// Expanded output channel
	typedef logic [`CHAN_W-1:0] chanT;

endpackage

`default_nettype wire

// File: source/pixelClockGen.sv
`timescale 1ns/1ps
`default_nettype none

`include "videoOut_consts.svh"

// ==============================
// Pixel clock enable
// ==============================

module pixelClockGen (
	input  wire  CLK_48M,
	input  wire  nRESET,
	output logic pixelEnable
);

	// Position inside the current pixel slot
	logic [2:0] divCount;

	// Last master clock of a slot
	logic lastCount;

	assign lastCount = (divCount == 3'(`PIX_DIV - 1));

	// Free running divider, restarts at reset release
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			divCount <= 3'd0;
		end else if (lastCount) begin
			divCount <= 3'd0;
		end else begin
			divCount <= divCount + 3'd1;
		end
	end

	// Registered pulse, one clock wide
	// First one lands 8 clocks after reset is released
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			pixelEnable <= 1'b0;
		end else begin
			pixelEnable <= lastCount;
		end
	end

endmodule

`default_nettype wire

// File: source/hostWriteDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "videoOut_consts.svh"

// ==============================
// Host write decode
// ==============================

module hostWriteDecoder
	import hostBusPkg::*;
	import videoPkg::*;
(
	input  wire      CLK_48M,
	input  wire      nRESET,
	input  wire      hostWrite,
	input  hostAddrT hostAddr,
	input  hostDataT hostData,
	output logic     palWrite,
	output palIndexT palWriteIndex,
	output palEntryT palWriteData,
	output logic     shadow,
	output logic     paletteBank
);

	// Zone hits from the upper address bits
	logic palZone;
	logic latchZone;

	// Addressed latch bit and the value carried on A4
	latchSelT latchSel;
	logic     latchValue;

	assign palZone   = (palZoneT'(hostAddr[23:22]) == `ZONE_PAL);
	assign latchZone = (latchZoneT'(hostAddr[23:16]) == `ZONE_LATCH);

	assign latchSel   = hostAddr[3:1];
	assign latchValue = hostAddr[4];

	// Palette port, word index from A12..A1
	// Strobe is passed on in the same cycle
	assign palWrite      = hostWrite & palZone;
	assign palWriteIndex = hostAddr[12:1];
	assign palWriteData  = hostData;

	// Bit addressed latch
	// Data bus is ignored here, only the address matters
	// Other six latch bits have no function in this block
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			shadow      <= 1'b0;
			paletteBank <= 1'b0;
		end else if (hostWrite && latchZone) begin
			if (latchSel == `LATCH_SHADOW) begin
				shadow <= latchValue;
			end
			if (latchSel == `LATCH_PALBANK) begin
				paletteBank <= latchValue;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/paletteRam.sv
`timescale 1ns/1ps
`default_nettype none

`include "videoOut_consts.svh"

// ==============================
// Banked palette memory
// ==============================

module paletteRam
	import videoPkg::*;
(
	input  wire      CLK_48M,
	input  wire      paletteBank,
	input  wire      palWrite,
	input  palIndexT palWriteIndex,
	input  palEntryT palWriteData,
	input  palIndexT palReadIndex,
	output palEntryT palEntry
);

	// Two banks of 4096 entries
	palEntryT palMem [0:(2 ** (`PAL_INDEX_W + 1)) - 1];

	// Full RAM addresses
	palAddrT writeAddr;
	palAddrT readAddr;

	// Both sides follow the bank bit
	// Host writes always land in the bank on screen
	assign writeAddr = {paletteBank, palWriteIndex};
	assign readAddr  = {paletteBank, palReadIndex};

	// Host side, write on the edge
	always_ff @(posedge CLK_48M) begin
		if (palWrite) begin
			palMem[writeAddr] <= palWriteData;
		end
	end

	// Raster side, one clock read latency
	// Same address written this cycle returns the old entry
	always_ff @(posedge CLK_48M) begin
		palEntry <= palMem[readAddr];
	end

endmodule

`default_nettype wire

// File: source/colorExpand.sv
`timescale 1ns/1ps
`default_nettype none

// ==============================
// Colour expansion and blanking
// ==============================

module colorExpand
	import videoPkg::*;
(
	input  wire      CLK_48M,
	input  wire      nRESET,
	input  wire      pixelEnable,
	input  palEntryT palEntry,
	input  wire      shadow,
	input  wire      hBlankIn,
	input  wire      vBlankIn,
	output chanT     red,
	output chanT     green,
	output chanT     blue,
	output logic     hBlank,
	output logic     vBlank
);

	// One channel from nibble, low bit and dark
	// 6 bit value is nibble, low bit, then nibble MSB
	// Bit 6 catches the borrow when dark goes below zero
	function automatic chanT expandChan(
		input nibbleT nib,
		input logic   lowBit,
		input logic   dark
	);
		logic [6:0] level;
		chanT       wide;
		level = {1'b0, nib, lowBit, nib[3]} - {6'd0, dark};
		if (level[6]) begin
			wide = '0;
		end else begin
			// Fill the two LSBs from bits 4 and 3
			wide = {level[5:0], level[4:3]};
		end
		return wide;
	endfunction

	// Expanded channels before shadow
	chanT redFull;
	chanT greenFull;
	chanT blueFull;

	// Channels after shadow
	chanT redOut;
	chanT greenOut;
	chanT blueOut;

	// First stage of the hblank delay
	logic hBlankDly;

	assign redFull   = expandChan(palEntry[11:8], palEntry[14], palEntry[15]);
	assign greenFull = expandChan(palEntry[7:4],  palEntry[13], palEntry[15]);
	assign blueFull  = expandChan(palEntry[3:0],  palEntry[12], palEntry[15]);

	// Shadow halves everything
	assign redOut   = shadow ? {1'b0, redFull[7:1]}   : redFull;
	assign greenOut = shadow ? {1'b0, greenFull[7:1]} : greenFull;
	assign blueOut  = shadow ? {1'b0, blueFull[7:1]}  : blueFull;

	// ==============================
	// Output registers
	// ==============================

	// Everything moves only on the pixel enable
	// hblank trails vblank by one extra slot
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			red       <= '0;
			green     <= '0;
			blue      <= '0;
			hBlankDly <= 1'b0;
			hBlank    <= 1'b0;
			vBlank    <= 1'b0;
		end else if (pixelEnable) begin
			red       <= redOut;
			green     <= greenOut;
			blue      <= blueOut;
			hBlankDly <= hBlankIn;
			hBlank    <= hBlankDly;
			vBlank    <= vBlankIn;
		end
	end

endmodule

`default_nettype wire

// File: source/videoOutTop.sv
`timescale 1ns/1ps
`default_nettype none

// ==============================
// Video output stage
// ==============================

module videoOutTop
	import hostBusPkg::*;
	import videoPkg::*;
(
	input  wire      CLK_48M,
	input  wire      nRESET,
	// Host write bus
	input  wire      hostWrite,
	input  hostAddrT hostAddr,
	input  hostDataT hostData,
	// Raster side
	input  palIndexT palIndex,
	input  wire      hBlankIn,
	input  wire      vBlankIn,
	// Pixel out
	output chanT     red,
	output chanT     green,
	output chanT     blue,
	output logic     hBlank,
	output logic     vBlank,
	output logic     pixelCe
);

	// Pixel enable
	logic pixelEnable;

	// Host palette port
	logic     palWrite;
	palIndexT palWriteIndex;
	palEntryT palWriteData;

	// Latch bits
	logic shadow;
	logic paletteBank;

	// Entry for the current slot
	palEntryT palEntry;

	assign pixelCe = pixelEnable;

	pixelClockGen pixelClockGenInst (
		.CLK_48M     (CLK_48M),
		.nRESET      (nRESET),
		.pixelEnable (pixelEnable)
	);

	hostWriteDecoder hostWriteDecoderInst (
		.CLK_48M       (CLK_48M),
		.nRESET        (nRESET),
		.hostWrite     (hostWrite),
		.hostAddr      (hostAddr),
		.hostData      (hostData),
		.palWrite      (palWrite),
		.palWriteIndex (palWriteIndex),
		.palWriteData  (palWriteData),
		.shadow        (shadow),
		.paletteBank   (paletteBank)
	);

	// Raster index goes straight to the read port
	paletteRam paletteRamInst (
		.CLK_48M       (CLK_48M),
		.paletteBank   (paletteBank),
		.palWrite      (palWrite),
		.palWriteIndex (palWriteIndex),
		.palWriteData  (palWriteData),
		.palReadIndex  (palIndex),
		.palEntry      (palEntry)
	);

	colorExpand colorExpandInst (
		.CLK_48M     (CLK_48M),
		.nRESET      (nRESET),
		.pixelEnable (pixelEnable),
		.palEntry    (palEntry),
		.shadow      (shadow),
		.hBlankIn    (hBlankIn),
		.vBlankIn    (vBlankIn),
		.red         (red),
		.green       (green),
		.blue        (blue),
		.hBlank      (hBlank),
		.vBlank      (vBlank)
	);

endmodule

`default_nettype wire

// File: verification/videoOutTb_sva.sv
`timescale 1ns/1ps
`default_nettype none

// ==============================
// Pixel enable and output checks
// ==============================

module colorExpandSva
	import videoPkg::*;
(
	input wire  CLK_48M,
	input wire  nRESET,
	input wire  pixelEnable,
	input chanT red,
	input chanT green,
	input chanT blue,
	input wire  hBlank,
	input wire  vBlank
);

	// Running count of failed assertions
	int failCount = 0;

	// Enable is one clock wide
	enableSingle: assert property (
		@(posedge CLK_48M) disable iff (!nRESET)
		pixelEnable |=> !pixelEnable
	) else begin
		failCount++;
		$error("pixel enable high on two consecutive cycles");
	end

	// Blanking only moves on the edge that follows an enable
	blankOnPixel: assert property (
		@(posedge CLK_48M) disable iff (!nRESET)
		(hBlank != $past(hBlank) || vBlank != $past(vBlank)) |-> $past(pixelEnable)
	) else begin
		failCount++;
		$error("blanking changed without a pixel enable");
	end

	// Reset clears every output
	outputsInReset: assert property (
		@(posedge CLK_48M)
		!nRESET |=> (red == '0 && green == '0 && blue == '0 && !hBlank && !vBlank)
	) else begin
		failCount++;
		$error("outputs not low during reset");
	end

endmodule

bind colorExpand colorExpandSva sva (
	.CLK_48M     (CLK_48M),
	.nRESET      (nRESET),
	.pixelEnable (pixelEnable),
	.red         (red),
	.green       (green),
	.blue        (blue),
	.hBlank      (hBlank),
	.vBlank      (vBlank)
);

`default_nettype wire

// File: verification/videoOutTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "videoOut_consts.svh"

module videoOutTb
	import hostBusPkg::*;
	import videoPkg::*;
();

	// ==============================
	// DUT connections
	// ==============================

	logic     CLK_48M;
	logic     nRESET;
	logic     hostWrite;
	hostAddrT hostAddr;
	hostDataT hostData;
	palIndexT palIndex;
	logic     hBlankIn;
	logic     vBlankIn;
	chanT     red;
	chanT     green;
	chanT     blue;
	logic     hBlank;
	logic     vBlank;
	logic     pixelCe;

	// Vector lines without the comment lines
	string lines[$];
	bit    vectorsLoaded;

	// Set while in the first cycle of a slot
	bit atSlotStart;

	// Overall counts and the open test
	int    checkCount;
	int    errorCount;
	int    testCount;
	int    testChecks;
	int    testErrors;
	int    testNum;
	string testName;
	bit    testOpen;

	videoOutTop DUT (
		.CLK_48M   (CLK_48M),
		.nRESET    (nRESET),
		.hostWrite (hostWrite),
		.hostAddr  (hostAddr),
		.hostData  (hostData),
		.palIndex  (palIndex),
		.hBlankIn  (hBlankIn),
		.vBlankIn  (vBlankIn),
		.red       (red),
		.green     (green),
		.blue      (blue),
		.hBlank    (hBlank),
		.vBlank    (vBlank),
		.pixelCe   (pixelCe)
	);

	// 100 ns period
	initial begin
		CLK_48M = 1'b0;
		forever #50 CLK_48M = ~CLK_48M;
	end

	task automatic checkValue(input string what, input logic [7:0] got, input logic [7:0] exp);
		checkCount++;
		testChecks++;
		assert (got === exp) else begin
			$display("ERR @%0t ns: %s is %h, expected %h", $time, what, got, exp);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic finishTest;
		if (testOpen) begin
			$display("Test %0d %s: %0d checks, %0d errors", testNum, testName,
				testChecks, testErrors);
			testCount++;
			testOpen = 1'b0;
		end
	endtask

	task automatic startTest(input int num, input string name);
		finishTest();
		testNum    = num;
		testName   = name;
		testChecks = 0;
		testErrors = 0;
		testOpen   = 1'b1;
	endtask

	task automatic checkOutputsLow(input string when);
		checkValue({when, " red"}, red, 8'h00);
		checkValue({when, " green"}, green, 8'h00);
		checkValue({when, " blue"}, blue, 8'h00);
		checkValue({when, " hBlank"}, 8'(hBlank), 8'h00);
		checkValue({when, " vBlank"}, 8'(vBlank), 8'h00);
	endtask

	// Stop just after the edge that closes the current slot
	task automatic waitSlotEnd;
		@(negedge CLK_48M);
		while (!pixelCe) begin
			@(negedge CLK_48M);
		end
		@(posedge CLK_48M);
		#1;
	endtask

	// ==============================
	// Reset and pixel enable cadence
	// ==============================

	task automatic checkReset;
		int n;
		startTest(1, "reset");
		// Bright entry at index 0 and both blanking inputs high
		// A load outside the pixel enable would then show on the outputs
		hostAddr = 24'h400000;
		hostData = 16'h7FFF;
		hBlankIn = 1'b1;
		vBlankIn = 1'b1;
		// 8 clocks held in reset
		for (n = 1; n <= 8; n++) begin
			@(posedge CLK_48M);
			#1;
			checkOutputsLow("in reset");
			checkValue("in reset pixelCe", 8'(pixelCe), 8'h00);
			// Palette write once the bank bit has been cleared
			hostWrite = (n == 1);
		end
		nRESET = 1'b1;
		// First pulse 8 clocks after release and every 8 after that
		for (n = 1; n <= 2 * `PIX_DIV; n++) begin
			@(posedge CLK_48M);
			#1;
			checkValue($sformatf("pixelCe cycle %0d", n), 8'(pixelCe), 8'(n % `PIX_DIV == 0));
			if (n <= `PIX_DIV) begin
				checkOutputsLow("after reset");
			end
			// Blanking back to idle in the cycle after the first pulse
			if (n == `PIX_DIV + 1) begin
				hBlankIn = 1'b0;
				vBlankIn = 1'b0;
			end
		end
		atSlotStart = 1'b0;
	endtask

	// One host write with a single cycle strobe
	task automatic hostWriteCycle(input hostAddrT addr, input hostDataT data);
		hostWrite = 1'b1;
		hostAddr  = addr;
		hostData  = data;
		@(posedge CLK_48M);
		#1;
		hostWrite   = 1'b0;
		atSlotStart = 1'b0;
	endtask

	// Drive one slot and compare what it loads at its closing pulse
	task automatic runPixelSlot(input int vec, input palIndexT idx, input logic hIn,
		input logic vIn, input chanT expR, input chanT expG, input chanT expB,
		input logic expH, input logic expV);
		if (!atSlotStart) begin
			waitSlotEnd();
		end
		palIndex = idx;
		hBlankIn = hIn;
		vBlankIn = vIn;
		waitSlotEnd();
		checkValue($sformatf("vector %0d red", vec), red, expR);
		checkValue($sformatf("vector %0d green", vec), green, expG);
		checkValue($sformatf("vector %0d blue", vec), blue, expB);
		checkValue($sformatf("vector %0d hBlank", vec), 8'(hBlank), 8'(expH));
		checkValue($sformatf("vector %0d vBlank", vec), 8'(vBlank), 8'(expV));
		atSlotStart = 1'b1;
	endtask

	task automatic readVectors(output bit ok);
		int    fd;
		int    status;
		string line;
		fd = $fopen("verification/videoOut_vectors.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			while (!$feof(fd)) begin
				status = $fgets(line, fd);
				if (status > 1 && line[0] != "#") begin
					lines.push_back(line);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic runVectors;
		string    line;
		byte      kind;
		int       fields;
		int       num;
		string    name;
		hostAddrT addr;
		hostDataT data;
		palIndexT idx;
		logic     hIn;
		logic     vIn;
		chanT     expR;
		chanT     expG;
		chanT     expB;
		logic     expH;
		logic     expV;
		foreach (lines[i]) begin
			line   = lines[i];
			kind   = line[0];
			fields = 0;
			case (kind)
				"T": begin
					fields = $sscanf(line, "T %d %s", num, name);
					if (fields == 2) begin
						startTest(num, name);
					end
				end
				"W": begin
					fields = $sscanf(line, "W %h %h", addr, data);
					if (fields == 2) begin
						hostWriteCycle(addr, data);
					end
				end
				"P": begin
					fields = $sscanf(line, "P %h %h %h %h %h %h %h %h", idx, hIn, vIn,
						expR, expG, expB, expH, expV);
					if (fields == 8) begin
						runPixelSlot(i, idx, hIn, vIn, expR, expG, expB, expH, expV);
					end
				end
				default: begin
					fields = -1;
				end
			endcase
			if (fields <= 0 || (kind == "P" && fields != 8) || (kind != "P" && fields != 2)) begin
				$display("Vector %0d could not be parsed", i);
				errorCount++;
			end
		end
	endtask

	// ==============================
	// Main flow and watchdog
	// ==============================

	initial begin : mainFlow
		bit loaded;
		int assertFails;
		nRESET    = 1'b0;
		hostWrite = 1'b0;
		hostAddr  = '0;
		hostData  = '0;
		palIndex  = '0;
		hBlankIn  = 1'b0;
		vBlankIn  = 1'b0;
		readVectors(loaded);
		if (!loaded) begin
			$display("Could not open verification/videoOut_vectors.txt");
			$display("** FAIL **");
		end else begin
			vectorsLoaded = 1'b1;
			checkReset();
			runVectors();
			finishTest();
			assertFails = DUT.colorExpandInst.sva.failCount;
			$display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
				testCount, checkCount, errorCount, assertFails);
			if (errorCount == 0 && assertFails == 0) begin
				$display("** PASS **");
			end else begin
				$display("** FAIL **");
			end
		end
		$finish;
	end

	// At most two slots per vector plus reset and margin
	initial begin : watchdog
		int limitCycles;
		wait (vectorsLoaded);
		limitCycles = lines.size() * `PIX_DIV * 2 + 200;
		#(limitCycles * 100);
		$display("Timeout: the run was still going after %0d clock cycles", limitCycles);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: videoOutTop.f
+incdir+source
source/hostBusPkg.sv
source/videoPkg.sv
source/pixelClockGen.sv
source/hostWriteDecoder.sv
source/paletteRam.sv
source/colorExpand.sv
source/videoOutTop.sv
verification/videoOutTb_sva.sv
verification/videoOutTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the video output testbench with Verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module videoOutTb -f videoOutTop.f -o videoOutSim

output=$(./obj_dir/videoOutSim 2>&1) || true
echo "$output"

if echo "$output" | grep -qF -- '** PASS **'; then
	exit 0
else
	exit 1
fi

// File: verification/videoOut_vectors.txt
# T number name | W address data | P index hBlankIn vBlankIn red green blue hBlank vBlank
# All fields hex, palette zone 4xxxxx with index in A12..A1, latch zone 3Axxxx
T 2 colour
W 400002 4A5C
W 400004 7FFF
W 400006 0000
W 400246 3123
W 000002 7FFF
P 001 0 0 AD 52 C6 0 0
P 002 0 0 FF FF FF 0 0
P 003 0 0 00 00 00 0 0
P 123 0 0 10 29 39 0 0
T 3 dark
W 400020 8A5C
W 400022 8000
W 400024 F100
W 400026 8F00
P 010 0 0 A1 4E C2 0 0
P 011 0 0 00 00 00 0 0
P 012 0 0 14 04 04 0 0
P 013 0 0 F3 00 00 0 0
T 4 shadow
W 3A0010 0000
P 001 0 0 56 29 63 0 0
P 002 0 0 7F 7F 7F 0 0
W 3A0000 0000
P 001 0 0 AD 52 C6 0 0
T 5 bank
W 4000A0 7FFF
W 3A001E 0000
W 4000A0 3123
P 050 0 0 10 29 39 0 0
W 3A000E 0000
P 050 0 0 FF FF FF 0 0
P 001 0 0 AD 52 C6 0 0
W 3A001E 0000
P 050 0 0 10 29 39 0 0
T 6 blanking
P 050 1 0 10 29 39 0 0
P 050 1 1 10 29 39 1 1
P 050 0 1 10 29 39 1 1
P 050 0 0 10 29 39 0 0
P 050 1 0 10 29 39 0 0
P 050 0 0 10 29 39 1 0
